// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    localparam int TAG_WIDTH = 6;

    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [31:0]          addr_t;
    typedef logic [63:0]          data_t;

    // Processor side
    typedef struct packed {
        tag_t tag;
        logic is_store;
    } instr_req_t;

    typedef struct packed {
        tag_t  tag;
        addr_t addr;
        data_t value;
    } data_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t value;
    } completion_t;

    // One slot of the ring queue
    typedef struct packed {
        logic  valid;
        logic  resolved;
        logic  dispatched;
        logic  complete;
        logic  is_store;
        tag_t  tag;
        addr_t addr;
        data_t value;
    } lsu_entry_t;

    typedef enum logic [1:0] {
        ISSUE_NONE,
        ISSUE_FWD,
        ISSUE_MEM
    } issue_kind_e;

    typedef struct packed {
        logic        valid;
        issue_kind_e kind;
        logic [7:0]  index;
        data_t       value;
    } issue_t;

    // Between the queue and the L1D master
    typedef struct packed {
        logic  is_store;
        addr_t addr;
        data_t value;
        tag_t  tag;
    } mem_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t value;
    } mem_rsp_t;

endpackage

// ==== hw/axi_lite_pkg.sv ====
package axi_lite_pkg;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // Write address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_aw_t;

    // Read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_ar_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        logic [63:0] data;
        axi_resp_t   resp;
    } axi_r_t;

endpackage

// ==== hw/load_issue_select.sv ====
module load_issue_select #(
    parameter int QUEUE_DEPTH = 8
) (
    input  lsu_pkg::lsu_entry_t            entries [QUEUE_DEPTH],
    input  logic [$clog2(QUEUE_DEPTH)-1:0] head,
    input  logic [$clog2(QUEUE_DEPTH):0]   count,
    output lsu_pkg::issue_t                issue
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    always_comb begin
        logic [PTR_W-1:0] idx;
        logic             store_seen;
        logic             store_pending;
        logic             load_found;
        addr_t            store_addr;
        data_t            store_value;

        issue.valid   = 1'b0;
        issue.kind    = ISSUE_NONE;
        issue.index   = '0;
        issue.value   = '0;
        store_seen    = 1'b0;
        store_pending = 1'b0;
        load_found    = 1'b0;
        store_addr    = '0;
        store_value   = '0;

        // Oldest to youngest, remembering the youngest store passed so far
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            idx = head + PTR_W'(k);
            if (k < count && !load_found && entries[idx].valid) begin
                if (entries[idx].is_store) begin
                    store_seen  = 1'b1;
                    store_addr  = entries[idx].addr;
                    store_value = entries[idx].value;
                    if (!entries[idx].resolved) begin
                        store_pending = 1'b1;
                    end
                end else if (entries[idx].resolved && !entries[idx].dispatched &&
                             !entries[idx].complete) begin
                    // Younger loads would see the same unresolved store, so stop here
                    load_found = 1'b1;
                    if (!store_pending) begin
                        issue.valid = 1'b1;
                        issue.index = 8'(idx);
                        if (store_seen && store_addr == entries[idx].addr) begin
                            issue.kind  = ISSUE_FWD;
                            issue.value = store_value;
                        end else begin
                            issue.kind = ISSUE_MEM;
                        end
                    end
                end
            end
        end

        // Stores only go out from the head, keeping memory in program order
        if (!issue.valid && count != '0 && entries[head].valid && entries[head].is_store &&
            entries[head].resolved && !entries[head].dispatched && !entries[head].complete) begin
            issue.valid = 1'b1;
            issue.kind  = ISSUE_MEM;
            issue.index = 8'(head);
        end
    end

endmodule

// ==== hw/lsu_queue.sv ====
module lsu_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                           clk_in,
    input  logic                           rst_N_in,
    input  logic                           instr_valid,
    input  lsu_pkg::instr_req_t            instr,
    output logic                           instr_ready,
    input  logic                           data_valid,
    input  lsu_pkg::data_req_t             data,
    output logic                           data_ready,
    output logic                           cpl_valid,
    output lsu_pkg::completion_t           cpl,
    output lsu_pkg::lsu_entry_t            entries [QUEUE_DEPTH],
    output logic [$clog2(QUEUE_DEPTH)-1:0] head,
    output logic [$clog2(QUEUE_DEPTH):0]   count,
    input  lsu_pkg::issue_t                issue,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output lsu_pkg::mem_req_t              mem_req,
    input  logic                           mem_rsp_valid,
    input  lsu_pkg::mem_rsp_t              mem_rsp
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] issue_idx;
    logic [PTR_W-1:0] cpl_idx;
    logic             alloc;
    logic             data_take;
    logic             retire;
    logic             cpl_found;

    // --------------------
    // Status and handshakes
    // --------------------
    assign tail        = head + count[PTR_W-1:0];
    assign instr_ready = (count != (PTR_W+1)'(QUEUE_DEPTH));
    assign alloc       = instr_valid && instr_ready;
    assign data_take   = data_valid && data_ready;
    // Head slot already emitted, so it can leave the ring
    assign retire      = (count != '0) && !entries[head].valid;
    assign issue_idx   = issue.index[PTR_W-1:0];

    always_comb begin
        data_ready = 1'b0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (entries[i].valid && !entries[i].resolved) begin
                data_ready = 1'b1;
            end
        end
    end

    // Memory request straight from the selected entry
    assign mem_req_valid    = issue.valid && (issue.kind == ISSUE_MEM);
    assign mem_req.is_store = entries[issue_idx].is_store;
    assign mem_req.addr     = entries[issue_idx].addr;
    assign mem_req.value    = entries[issue_idx].value;
    assign mem_req.tag      = entries[issue_idx].tag;

    // Complete entry nearest the head
    always_comb begin
        logic [PTR_W-1:0] idx;

        cpl_found = 1'b0;
        cpl_idx   = head;
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            idx = head + PTR_W'(k);
            if (!cpl_found && k < count && entries[idx].valid && entries[idx].complete) begin
                cpl_found = 1'b1;
                cpl_idx   = idx;
            end
        end
    end

    // --------------------
    // Entry state
    // --------------------
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entries[i] <= '0;
            end
            head      <= '0;
            count     <= '0;
            cpl_valid <= 1'b0;
        end else begin
            if (alloc) begin
                entries[tail].valid      <= 1'b1;
                entries[tail].resolved   <= 1'b0;
                entries[tail].dispatched <= 1'b0;
                entries[tail].complete   <= 1'b0;
                entries[tail].is_store   <= instr.is_store;
                entries[tail].tag        <= instr.tag;
            end

            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                // Address and store data, matched by tag
                if (data_take && entries[i].valid && !entries[i].resolved &&
                    entries[i].tag == data.tag) begin
                    entries[i].resolved <= 1'b1;
                    entries[i].addr     <= data.addr;
                    if (entries[i].is_store) begin
                        entries[i].value <= data.value;
                    end
                end
                if (mem_rsp_valid && entries[i].valid && entries[i].dispatched &&
                    !entries[i].complete && entries[i].tag == mem_rsp.tag) begin
                    entries[i].value    <= mem_rsp.value;
                    entries[i].complete <= 1'b1;
                end
            end

            if (issue.valid && issue.kind == ISSUE_FWD) begin
                entries[issue_idx].value    <= issue.value;
                entries[issue_idx].complete <= 1'b1;
            end
            if (mem_req_valid && mem_req_ready) begin
                entries[issue_idx].dispatched <= 1'b1;
            end

            // Emitted entries drop valid and wait to reach the head
            cpl_valid <= cpl_found;
            if (cpl_found) begin
                entries[cpl_idx].valid <= 1'b0;
            end

            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (PTR_W+1)'(alloc) - (PTR_W+1)'(retire);
        end
    end

    always_ff @(posedge clk_in) begin
        if (cpl_found) begin
            cpl.tag   <= entries[cpl_idx].tag;
            cpl.value <= entries[cpl_idx].value;
        end
    end

endmodule

// ==== hw/l1d_axi_master.sv ====
module l1d_axi_master (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  logic                  mem_req_valid,
    output logic                  mem_req_ready,
    input  lsu_pkg::mem_req_t     mem_req,
    output logic                  mem_rsp_valid,
    output lsu_pkg::mem_rsp_t     mem_rsp,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_lite_pkg::axi_aw_t aw,
    output logic                  wvalid,
    input  logic                  wready,
    output axi_lite_pkg::axi_w_t  w,
    input  logic                  bvalid,
    output logic                  bready,
    input  axi_lite_pkg::axi_b_t  b,
    output logic                  arvalid,
    input  logic                  arready,
    output axi_lite_pkg::axi_ar_t ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  axi_lite_pkg::axi_r_t  r
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP
    } state_e;

    state_e   state;
    mem_req_t req_q;
    logic     addr_done;
    logic     rsp_take;

    assign mem_req_ready = (state == ST_IDLE);
    assign bready        = 1'b1;
    assign rready        = 1'b1;

    // Payload of the held request, full strobe
    assign aw.addr = req_q.addr;
    assign aw.prot = 3'b000;
    assign ar.addr = req_q.addr;
    assign ar.prot = 3'b000;
    assign w.data  = req_q.value;
    assign w.strb  = '1;

    // Each valid is either gone already or being taken this cycle
    assign addr_done = (!awvalid || awready) && (!wvalid || wready) && (!arvalid || arready);
    assign rsp_take  = (state == ST_RESP) && (req_q.is_store ? bvalid : rvalid);

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state         <= ST_IDLE;
            awvalid       <= 1'b0;
            wvalid        <= 1'b0;
            arvalid       <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_rsp_valid <= rsp_take;
            case (state)
                ST_IDLE: begin
                    if (mem_req_valid) begin
                        state   <= ST_ADDR;
                        awvalid <= mem_req.is_store;
                        wvalid  <= mem_req.is_store;
                        arvalid <= !mem_req.is_store;
                    end
                end
                ST_ADDR: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (addr_done) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_take) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // No ID on the bus, so the tag comes from the held request
    always_ff @(posedge clk_in) begin
        if (mem_req_valid && mem_req_ready) begin
            req_q <= mem_req;
        end
        if (rsp_take) begin
            mem_rsp.tag   <= req_q.tag;
            mem_rsp.value <= req_q.is_store ? req_q.value : r.data;
        end
    end

endmodule

// ==== hw/lsu_top.sv ====
module lsu_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  logic                  instr_valid,
    input  lsu_pkg::instr_req_t   instr,
    output logic                  instr_ready,
    input  logic                  data_valid,
    input  lsu_pkg::data_req_t    data,
    output logic                  data_ready,
    output logic                  cpl_valid,
    output lsu_pkg::completion_t  cpl,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_lite_pkg::axi_aw_t aw,
    output logic                  wvalid,
    input  logic                  wready,
    output axi_lite_pkg::axi_w_t  w,
    input  logic                  bvalid,
    output logic                  bready,
    input  axi_lite_pkg::axi_b_t  b,
    output logic                  arvalid,
    input  logic                  arready,
    output axi_lite_pkg::axi_ar_t ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  axi_lite_pkg::axi_r_t  r
);
    import lsu_pkg::*;

    lsu_entry_t                   entries [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0] head;
    logic [$clog2(QUEUE_DEPTH):0]   count;
    issue_t                       issue;
    logic                         mem_req_valid;
    logic                         mem_req_ready;
    mem_req_t                     mem_req;
    logic                         mem_rsp_valid;
    mem_rsp_t                     mem_rsp;

    lsu_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_lsu_queue (
        .clk_in       (clk_in),
        .rst_N_in     (rst_N_in),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .data_valid   (data_valid),
        .data         (data),
        .data_ready   (data_ready),
        .cpl_valid    (cpl_valid),
        .cpl          (cpl),
        .entries      (entries),
        .head         (head),
        .count        (count),
        .issue        (issue),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req      (mem_req),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp      (mem_rsp)
    );

    // Combinational pick of the next forward or memory access
    load_issue_select #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_load_issue_select (
        .entries(entries),
        .head   (head),
        .count  (count),
        .issue  (issue)
    );

    l1d_axi_master i_l1d_axi_master (
        .clk_in       (clk_in),
        .rst_N_in     (rst_N_in),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req      (mem_req),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp      (mem_rsp),
        .awvalid      (awvalid),
        .awready      (awready),
        .aw           (aw),
        .wvalid       (wvalid),
        .wready       (wready),
        .w            (w),
        .bvalid       (bvalid),
        .bready       (bready),
        .b            (b),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r)
    );

endmodule

// ==== dv/lsu_props.sv ====
module lsu_props #(
    parameter int QUEUE_DEPTH = 8
) (
    input logic                 clk_in,
    input logic                 rst_N_in,
    input logic                 awvalid,
    input logic                 awready,
    input logic                 wvalid,
    input logic                 wready,
    input logic                 arvalid,
    input logic                 arready,
    input logic                 bvalid,
    input logic                 bready,
    input logic                 rvalid,
    input logic                 rready,
    input logic                 instr_valid,
    input logic                 instr_ready,
    input logic                 cpl_valid,
    input lsu_pkg::completion_t cpl
);

    int   failures = 0;
    int   outstanding;
    logic rsp_pending;

    // Between an accepted AW or AR and its B or R
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            rsp_pending <= 1'b0;
        end else if ((bvalid && bready) || (rvalid && rready)) begin
            rsp_pending <= 1'b0;
        end else if ((awvalid && awready) || (arvalid && arready)) begin
            rsp_pending <= 1'b1;
        end
    end

    // Accepted instructions not yet seen on cpl, never more than the queue holds
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(instr_valid && instr_ready) - int'(cpl_valid);
        end
    end

    // --------------------
    // AXI4-Lite master rules
    // --------------------
    assert property (@(posedge clk_in) disable iff (!rst_N_in)
        awvalid && !awready |=> awvalid)
        else begin failures++; $error("AWVALID dropped before AWREADY"); end

    assert property (@(posedge clk_in) disable iff (!rst_N_in)
        wvalid && !wready |=> wvalid)
        else begin failures++; $error("WVALID dropped before WREADY"); end

    assert property (@(posedge clk_in) disable iff (!rst_N_in)
        arvalid && !arready |=> arvalid)
        else begin failures++; $error("ARVALID dropped before ARREADY"); end

    assert property (@(posedge clk_in) disable iff (!rst_N_in)
        rsp_pending |-> !$rose(awvalid) && !$rose(arvalid))
        else begin failures++; $error("New AW or AR while a response is pending"); end

    // --------------------
    // Queue and completion
    // --------------------
    assert property (@(posedge clk_in) disable iff (!rst_N_in)
        outstanding == QUEUE_DEPTH |-> !instr_ready)
        else begin failures++; $error("instr_ready high with a full queue"); end

    assert property (@(posedge clk_in) disable iff (!rst_N_in)
        cpl_valid |-> !$isunknown(cpl))
        else begin failures++; $error("Unknown bits on cpl"); end

endmodule

// ==== dv/lsu_tb.sv ====
module lsu_tb;
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    localparam int    DEPTH          = 8;
    localparam int    CYCLES_PER_ROW = 60;
    localparam int    MAX_DELAY      = 7;
    localparam logic  LD             = 1'b0;
    localparam logic  ST             = 1'b1;
    localparam data_t MEM_FILL       = 64'hC3A5_0F96_5A3C_E10F;

    typedef struct packed {
        logic [3:0] group;
        logic       is_store;
        tag_t       tag;
        addr_t      addr;
        data_t      value;
        logic [3:0] delay;
        data_t      expected;
    } row_t;

    logic        clk_in;
    logic        rst_N_in;
    logic        instr_valid;
    instr_req_t  instr;
    logic        instr_ready;
    logic        data_valid;
    data_req_t   data;
    logic        data_ready;
    logic        cpl_valid;
    completion_t cpl;
    logic        awvalid;
    logic        awready = 1'b0;
    axi_aw_t     aw;
    logic        wvalid;
    logic        wready = 1'b0;
    axi_w_t      w;
    logic        bvalid = 1'b0;
    logic        bready;
    axi_b_t      b = '0;
    logic        arvalid;
    logic        arready = 1'b0;
    axi_ar_t     ar;
    logic        rvalid = 1'b0;
    logic        rready;
    axi_r_t      r = '0;

    row_t        rows[$];
    data_t       mem_model [addr_t];
    data_t       exp_mem [addr_t];
    data_t       exp_by_tag [64];
    logic [63:0] pending = '0;
    int          issued = 0;
    int          completed = 0;
    int          errors = 0;
    int          cycles = 0;
    int          timeout_limit = 0;
    logic [31:0] rnd_state = 32'd56;

    // L1D slave state
    logic        aw_hs = 1'b0;
    logic        w_hs = 1'b0;
    logic        ar_hs = 1'b0;
    logic        have_aw = 1'b0;
    logic        have_w = 1'b0;
    addr_t       aw_hold;
    addr_t       ar_hold;
    addr_t       wr_addr;
    data_t       w_hold;
    data_t       wr_data;

    lsu_top #(
        .QUEUE_DEPTH(DEPTH)
    ) i_lsu_top (.*);

    bind lsu_top lsu_props #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_lsu_props (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready),
        .arvalid    (arvalid),
        .arready    (arready),
        .bvalid     (bvalid),
        .bready     (bready),
        .rvalid     (rvalid),
        .rready     (rready),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .cpl_valid  (cpl_valid),
        .cpl        (cpl)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Contents of an address nobody has written
    function automatic data_t mem_default(input addr_t a);
        return data_t'(a) ^ MEM_FILL;
    endfunction

    function automatic void add_row(input int group, input logic is_store, input int tag,
                                    input addr_t addr, input data_t value, input int delay);
        row_t row;
        row.group    = 4'(group);
        row.is_store = is_store;
        row.tag      = tag_t'(tag);
        row.addr     = addr;
        row.value    = value;
        row.delay    = 4'(delay);
        row.expected = '0;
        rows.push_back(row);
    endfunction

    // Program-order memory image gives each row its completion value
    function automatic void compute_expected();
        row_t row;
        for (int k = 0; k < rows.size(); k++) begin
            row = rows[k];
            if (row.is_store) begin
                exp_mem[row.addr] = row.value;
                row.expected      = row.value;
            end else if (exp_mem.exists(row.addr)) begin
                row.expected = exp_mem[row.addr];
            end else begin
                row.expected = mem_default(row.addr);
            end
            rows[k] = row;
        end
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            abort_run($sformatf("Fail at time %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic send_instr(input row_t row);
        while (!instr_ready) @(negedge clk_in);
        instr_valid          = 1'b1;
        instr.tag            = row.tag;
        instr.is_store       = row.is_store;
        exp_by_tag[row.tag]  = row.expected;
        pending[row.tag]     = 1'b1;
        issued++;
        @(negedge clk_in);
        instr_valid = 1'b0;
    endtask

    task automatic send_data(input row_t row);
        while (!data_ready) @(negedge clk_in);
        data_valid = 1'b1;
        data.tag   = row.tag;
        data.addr  = row.addr;
        data.value = row.value;
        @(negedge clk_in);
        data_valid = 1'b0;
    endtask

    // --------------------
    // L1D AXI4-Lite slave
    // --------------------
    always @(negedge clk_in) begin
        if (!rst_N_in) begin
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            bvalid  = 1'b0;
            rvalid  = 1'b0;
            have_aw = 1'b0;
            have_w  = 1'b0;
            aw_hs   = 1'b0;
            w_hs    = 1'b0;
            ar_hs   = 1'b0;
        end else begin
            // Handshakes of the rising edge just passed
            if (bvalid && bready) bvalid = 1'b0;
            if (rvalid && rready) rvalid = 1'b0;
            if (aw_hs) begin
                have_aw = 1'b1;
                wr_addr = aw_hold;
            end
            if (w_hs) begin
                have_w  = 1'b1;
                wr_data = w_hold;
            end
            if (have_aw && have_w) begin
                mem_model[wr_addr] = wr_data;
                have_aw            = 1'b0;
                have_w             = 1'b0;
                bvalid             = 1'b1;
                b.resp             = RESP_OKAY;
            end
            if (ar_hs) begin
                rvalid = 1'b1;
                r.data = mem_model.exists(ar_hold) ? mem_model[ar_hold] : mem_default(ar_hold);
                r.resp = RESP_OKAY;
            end
            rnd_state = xorshift32(rnd_state);
            awready   = |rnd_state[1:0];
            wready    = |rnd_state[3:2];
            arready   = |rnd_state[5:4];
            // What the coming rising edge will take
            aw_hs   = awvalid && awready;
            aw_hold = aw.addr;
            w_hs    = wvalid && wready;
            w_hold  = w.data;
            // Every store writes the whole word
            if (w_hs) begin
                check("w.strb", w.strb, 8'hFF);
            end
            ar_hs   = arvalid && arready;
            ar_hold = ar.addr;
        end
    end

    // --------------------
    // Scoreboard and timeout
    // --------------------
    always @(negedge clk_in) begin
        if (i_lsu_top.i_lsu_props.failures != 0) begin
            abort_run("A bound assertion on lsu_top failed");
        end
        if (rst_N_in && cpl_valid) begin
            check($sformatf("pending (tag %0d)", cpl.tag), pending[cpl.tag], 1'b1);
            check($sformatf("cpl.value (tag %0d)", cpl.tag), cpl.value, exp_by_tag[cpl.tag]);
            pending[cpl.tag] = 1'b0;
            completed++;
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (timeout_limit != 0 && cycles > timeout_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d of %0d instructions completed",
                                cycles, completed, issued));
        end
    end

    initial begin
        int first;
        int last;

        rst_N_in    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        data_valid  = 1'b0;
        data        = '0;

        // Untouched address reads the fill pattern
        add_row(1, LD, 1, 32'h0000_0100, 64'h0, 0);
        // Load data first, store data later, load forwards
        add_row(2, ST, 2, 32'h0000_0200, 64'h1111_2222_3333_4444, 3);
        add_row(2, LD, 3, 32'h0000_0200, 64'h0, 0);
        // Store, then a load after it has retired
        add_row(3, ST, 4, 32'h0000_0300, 64'hDEAD_BEEF_0BAD_F00D, 0);
        add_row(4, LD, 5, 32'h0000_0300, 64'h0, 0);
        // Eight held instructions fill the queue
        add_row(5, ST, 10, 32'h0000_0400, 64'hA0A0_0101_B1B1_0202, 5);
        add_row(5, LD, 11, 32'h0000_0400, 64'h0, 1);
        add_row(5, LD, 12, 32'h0000_0500, 64'h0, 0);
        add_row(5, ST, 13, 32'h0000_0408, 64'h0123_4567_89AB_CDEF, 2);
        add_row(5, LD, 14, 32'h0000_0408, 64'h0, 6);
        add_row(5, LD, 15, 32'h0000_0300, 64'h0, 3);
        add_row(5, ST, 16, 32'h0000_0410, 64'hFEDC_BA98_7654_3210, 4);
        add_row(5, LD, 17, 32'h0000_0100, 64'h0, 7);
        // Mixed rows under L1D back-pressure
        add_row(6, ST, 20, 32'h0000_0600, 64'h6000_0000_0000_0020, 2);
        add_row(6, LD, 21, 32'h0000_0600, 64'h0, 0);
        add_row(6, ST, 22, 32'h0000_0608, 64'h6080_0000_0000_0022, 5);
        add_row(6, LD, 23, 32'h0000_0400, 64'h0, 1);
        add_row(6, LD, 24, 32'h0000_0608, 64'h0, 3);
        add_row(6, ST, 25, 32'h0000_0600, 64'h6000_0000_0000_0025, 6);
        add_row(6, LD, 26, 32'h0000_0600, 64'h0, 4);
        add_row(7, LD, 30, 32'h0000_0600, 64'h0, 3);
        add_row(7, ST, 31, 32'h0000_0700, 64'h7000_0000_0000_0031, 0);
        add_row(7, ST, 32, 32'h0000_0708, 64'h7080_0000_0000_0032, 6);
        add_row(7, LD, 33, 32'h0000_0708, 64'h0, 2);
        add_row(7, LD, 34, 32'h0000_0208, 64'h0, 5);
        add_row(7, ST, 35, 32'h0000_0200, 64'h2000_0000_0000_0035, 1);
        add_row(7, LD, 36, 32'h0000_0200, 64'h0, 4);
        add_row(7, LD, 37, 32'h0000_0410, 64'h0, 7);
        compute_expected();
        timeout_limit = rows.size() * CYCLES_PER_ROW;

        repeat (5) @(negedge clk_in);
        rst_N_in = 1'b1;
        @(negedge clk_in);
        check("instr_ready", instr_ready, 1'b1);
        check("data_ready", data_ready, 1'b0);
        check("cpl_valid", cpl_valid, 1'b0);
        check("awvalid", awvalid, 1'b0);
        check("wvalid", wvalid, 1'b0);
        check("arvalid", arvalid, 1'b0);

        // One group at a time, drained before the next
        first = 0;
        while (first < rows.size()) begin
            last = first;
            while (last + 1 < rows.size() && rows[last+1].group == rows[first].group) begin
                last++;
            end
            for (int k = first; k <= last; k++) begin
                send_instr(rows[k]);
            end
            check("instr_ready", instr_ready, (last - first + 1 == DEPTH) ? 1'b0 : 1'b1);
            for (int d = 0; d <= MAX_DELAY; d++) begin
                for (int k = first; k <= last; k++) begin
                    if (rows[k].delay == d) begin
                        send_data(rows[k]);
                    end
                end
                @(negedge clk_in);
            end
            while (completed != issued) @(negedge clk_in);
            repeat (2) @(negedge clk_in);
            check("instr_ready", instr_ready, 1'b1);
            first = last + 1;
        end

        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/lsu_pkg.sv
hw/axi_lite_pkg.sv
hw/load_issue_select.sv
hw/lsu_queue.sv
hw/l1d_axi_master.sv
hw/lsu_top.sv
dv/lsu_props.sv
dv/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
